//--- snappy_settings.svh
//////////////////////////////////////////////////
// sizes shared by the decompressor RTL
// literal-only streams, 16-byte beats
//////////////////////////////////////////////////
`ifndef SNAPPY_SETTINGS_SVH
`define SNAPPY_SETTINGS_SVH

// bytes per beat on the input and output side
`define SNAPPY_BEAT_BYTES 16

`define SNAPPY_IN_DEPTH 16 // input beat FIFO entries
`define SNAPPY_OUT_DEPTH 8 // output beat FIFO entries

// free entries left when almost full rises
`define SNAPPY_AFULL_MARGIN 3

`define SNAPPY_LEN_BITS 35 // compressed length width

`endif

//--- snappy_pkg.sv
//////////////////////////////////////////////////
// beat and payload types of the decompressor
// byte 0 of a beat is the first byte in stream order
//////////////////////////////////////////////////
`include "snappy_settings.svh"

package snappy_pkg;

	// one beat, byte 0 in the low bits
	typedef logic [`SNAPPY_BEAT_BYTES-1:0][7:0] beat_t;

	typedef logic [`SNAPPY_BEAT_BYTES-1:0] byte_mask_t; // one bit per byte

	typedef logic [`SNAPPY_LEN_BITS-1:0] comp_len_t; // length in bytes

	// scanner result for one input beat
	typedef struct packed {
		beat_t data;
		byte_mask_t lit; // literal bytes
		logic last; // beat reaches the compressed length
	} scan_beat_t;

	// packed output beat
	typedef struct packed {
		beat_t data;
		byte_mask_t byte_valid; // low aligned
		logic last;
	} out_beat_t;

endpackage

//--- beat_fifo.sv
//////////////////////////////////////////////////
// synchronous FIFO, head shown without read delay
// pushes into a full FIFO are dropped unless a pop frees a slot
//////////////////////////////////////////////////
`include "snappy_settings.svh"

module beat_fifo #(
	parameter type data_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic rst_n_i,
	input logic push_i,
	input data_t data_i,
	input logic pop_i,
	output data_t data_o,
	output logic empty_o,
	output logic almost_full_o
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	data_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic do_push;
	logic do_pop;

	// wrap at DEPTH, so any depth works
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign do_pop = pop_i && !empty_o;
	assign do_push = push_i && ((count_q != CNT_W'(DEPTH)) || do_pop);

	assign data_o = mem[rd_ptr_q]; // first word falls through
	assign empty_o = (count_q == '0);
	assign almost_full_o = (DEPTH - int'(count_q)) <= `SNAPPY_AFULL_MARGIN;

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr_q] <= data_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (do_push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (do_pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({do_push, do_pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: ; // both or neither, count holds
			endcase
		end
	end

endmodule

//--- token_scanner.sv
//////////////////////////////////////////////////
// preparser for literal-only streams
// every tag must have its low two bits at zero
// pops only between start and the last beat of a stream
//////////////////////////////////////////////////
`include "snappy_settings.svh"

module token_scanner (
	input logic clk,
	input logic rst_n_i,
	input logic start_i,
	input snappy_pkg::comp_len_t comp_len_i,
	input snappy_pkg::beat_t beat_i,
	input logic beat_valid_i,
	input logic hold_i,
	output logic pop_o,
	output snappy_pkg::scan_beat_t scan_o,
	output logic scan_valid_o
);
	import snappy_pkg::*;

	localparam int NB = `SNAPPY_BEAT_BYTES;

	comp_len_t len_q; // length latched at start
	comp_len_t used_q; // bytes consumed so far
	comp_len_t remain;
	logic active_q; // stream in progress
	logic [6:0] left_q; // literal bytes still owed by the last tag
	logic [6:0] left_d;
	byte_mask_t lit_d;
	logic last_d;
	logic start_ok;

	assign start_ok = start_i && !active_q;
	assign remain = len_q - used_q;
	assign last_d = (remain <= comp_len_t'(NB));
	assign pop_o = active_q && beat_valid_i && !hold_i;

	// walk the bytes in order, the count runs across beats
	always_comb begin
		left_d = left_q;
		lit_d = '0;
		for (int i = 0; i < NB; i++) begin
			if (comp_len_t'(i) < remain) begin // past the length is garbage
				if (left_d == '0) begin
					// tag byte, upper six bits hold length - 1
					left_d = {1'b0, beat_i[i][7:2]} + 7'd1;
				end else begin
					lit_d[i] = 1'b1;
					left_d = left_d - 7'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start_ok) begin
			len_q <= comp_len_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			active_q <= 1'b0;
			used_q <= '0;
			left_q <= '0;
			scan_valid_o <= 1'b0;
		end else begin
			if (start_ok) begin
				active_q <= 1'b1;
				used_q <= '0;
				left_q <= '0;
			end else if (pop_o) begin
				used_q <= used_q + comp_len_t'(NB);
				left_q <= left_d;
				if (last_d) begin
					active_q <= 1'b0; // stream fully read
				end
			end
			if (!hold_i) begin
				scan_valid_o <= pop_o; // frozen while the packer holds
			end
		end
	end

	always_ff @(posedge clk) begin
		if (pop_o) begin
			scan_o <= '{data: beat_i, lit: lit_d, last: last_d};
		end
	end

endmodule

//--- literal_packer.sv
//////////////////////////////////////////////////
// packs literal bytes into full output beats
// a last input beat may cost one extra hold cycle
//////////////////////////////////////////////////
`include "snappy_settings.svh"

module literal_packer (
	input logic clk,
	input logic rst_n_i,
	input snappy_pkg::scan_beat_t scan_i,
	input logic scan_valid_i,
	input logic out_afull_i,
	output logic hold_o,
	output logic push_o,
	output snappy_pkg::out_beat_t out_o
);
	import snappy_pkg::*;

	localparam int NB = `SNAPPY_BEAT_BYTES;
	localparam int IW = $clog2(NB);
	localparam int CW = $clog2(2 * NB);

	logic [2*NB-1:0][7:0] acc_q; // held bytes, zero above cnt_q
	logic [CW-1:0] cnt_q;
	logic flush_q; // partial beat of a last input still owed
	beat_t packed_lit; // literals moved to the low bytes
	logic [CW-1:0] n_lit;
	logic [CW:0] total;
	logic [2*NB-1:0][7:0] merged;
	logic take;

	function automatic byte_mask_t low_mask(input logic [CW:0] k);
		logic [NB:0] m;
		m = ({{NB{1'b0}}, 1'b1} << k) - 1'b1;
		return m[NB-1:0];
	endfunction

	assign hold_o = out_afull_i || flush_q;
	assign take = scan_valid_i && !hold_o;

	always_comb begin
		packed_lit = '0;
		n_lit = '0;
		for (int i = 0; i < NB; i++) begin
			if (scan_i.lit[i]) begin
				packed_lit[n_lit[IW-1:0]] = scan_i.data[i];
				n_lit = n_lit + 1'b1;
			end
		end
	end

	// new bytes land right above the held ones
	assign merged = acc_q | ({{NB{8'h00}}, packed_lit} << {cnt_q, 3'b000});
	assign total = {1'b0, cnt_q} + {1'b0, n_lit};

	always_comb begin
		push_o = 1'b0;
		out_o.data = merged[NB-1:0];
		out_o.byte_valid = '1;
		out_o.last = 1'b0;
		if (flush_q) begin
			push_o = !out_afull_i;
			out_o.data = acc_q[NB-1:0];
			out_o.byte_valid = low_mask({1'b0, cnt_q});
			out_o.last = 1'b1;
		end else if (take) begin
			if (scan_i.last && (total <= NB)) begin
				push_o = 1'b1; // whole remainder fits one beat
				out_o.byte_valid = low_mask(total);
				out_o.last = 1'b1;
			end else if (total >= NB) begin
				push_o = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			acc_q <= '0;
			cnt_q <= '0;
			flush_q <= 1'b0;
		end else if (flush_q) begin
			if (!out_afull_i) begin
				acc_q <= '0;
				cnt_q <= '0;
				flush_q <= 1'b0;
			end
		end else if (take) begin
			if (scan_i.last && (total <= NB)) begin
				acc_q <= '0; // stream closed
				cnt_q <= '0;
			end else if (total >= NB) begin
				acc_q <= {{NB{8'h00}}, merged[2*NB-1:NB]};
				cnt_q <= CW'(total - NB);
				flush_q <= scan_i.last; // second beat due next cycle
			end else begin
				acc_q <= merged;
				cnt_q <= total[CW-1:0];
			end
		end
	end

endmodule

//--- output_writer.sv
//////////////////////////////////////////////////
// output register under a plain ready level
// start is taken only while idle
//////////////////////////////////////////////////
module output_writer (
	input logic clk,
	input logic rst_n_i,
	input logic start_i,
	input snappy_pkg::out_beat_t fifo_i,
	input logic fifo_empty_i,
	input logic wr_ready_i,
	output logic pop_o,
	output snappy_pkg::beat_t data_o,
	output snappy_pkg::byte_mask_t byte_valid_o,
	output logic last_o,
	output logic valid_o,
	output logic done_o,
	output logic idle_o
);
	logic xfer;
	logic end_xfer; // last beat of the stream leaves

	assign xfer = valid_o && wr_ready_i;
	assign end_xfer = xfer && last_o;

	// refill when the register is empty or drains this cycle
	assign pop_o = !fifo_empty_i && (!valid_o || wr_ready_i);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_o <= 1'b0;
			last_o <= 1'b0;
			done_o <= 1'b0;
			idle_o <= 1'b1;
		end else begin
			if (pop_o) begin
				valid_o <= 1'b1;
				last_o <= fifo_i.last;
			end else if (wr_ready_i) begin
				valid_o <= 1'b0;
				last_o <= 1'b0;
			end
			done_o <= end_xfer; // one cycle pulse
			if (end_xfer) begin
				idle_o <= 1'b1;
			end else if (start_i) begin
				idle_o <= 1'b0;
			end
		end
	end

	// held stable while wr_ready_i is low
	always_ff @(posedge clk) begin
		if (pop_o) begin
			data_o <= fifo_i.data;
			byte_valid_o <= fifo_i.byte_valid;
		end
	end

endmodule

//--- decompressor.sv
//////////////////////////////////////////////////
// literal-only decompressor front end
// input beats are taken while almost full is low
//////////////////////////////////////////////////
`include "snappy_settings.svh"

module decompressor (
	input logic clk,
	input logic rst_n_i,
	input snappy_pkg::beat_t data_i,
	input logic valid_i,
	input logic start_i,
	input snappy_pkg::comp_len_t compression_length_i,
	input logic wr_ready_i,
	output logic data_fifo_almost_full_o,
	output logic done_o,
	output logic idle_o,
	output logic last_o,
	output snappy_pkg::beat_t data_o,
	output snappy_pkg::byte_mask_t byte_valid_o,
	output logic valid_o
);
	import snappy_pkg::*;

	logic in_push;
	beat_t in_head;
	logic in_empty;
	logic scan_pop;
	scan_beat_t scan;
	logic scan_valid;
	logic pk_hold;
	logic pk_push;
	out_beat_t pk_beat;
	out_beat_t out_head;
	logic out_empty;
	logic out_afull;
	logic wr_pop;

	assign in_push = valid_i && !data_fifo_almost_full_o;

	beat_fifo #(.data_t(beat_t), .DEPTH(`SNAPPY_IN_DEPTH)) data_fifo0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.push_i(in_push),
		.data_i(data_i),
		.pop_i(scan_pop),
		.data_o(in_head),
		.empty_o(in_empty),
		.almost_full_o(data_fifo_almost_full_o)
	);

	token_scanner token_scanner0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.comp_len_i(compression_length_i),
		.beat_i(in_head),
		.beat_valid_i(!in_empty),
		.hold_i(pk_hold),
		.pop_o(scan_pop),
		.scan_o(scan),
		.scan_valid_o(scan_valid)
	);

	literal_packer literal_packer0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.scan_i(scan),
		.scan_valid_i(scan_valid),
		.out_afull_i(out_afull),
		.hold_o(pk_hold),
		.push_o(pk_push),
		.out_o(pk_beat)
	);

	beat_fifo #(.data_t(out_beat_t), .DEPTH(`SNAPPY_OUT_DEPTH)) out_fifo0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.push_i(pk_push),
		.data_i(pk_beat),
		.pop_i(wr_pop),
		.data_o(out_head),
		.empty_o(out_empty),
		.almost_full_o(out_afull)
	);

	output_writer output_writer0 (
		.clk(clk),
		.rst_n_i(rst_n_i),
		.start_i(start_i),
		.fifo_i(out_head),
		.fifo_empty_i(out_empty),
		.wr_ready_i(wr_ready_i),
		.pop_o(wr_pop),
		.data_o(data_o),
		.byte_valid_o(byte_valid_o),
		.last_o(last_o),
		.valid_o(valid_o),
		.done_o(done_o),
		.idle_o(idle_o)
	);

endmodule

//--- decompressor_checker.sv
//////////////////////////////////////////////////
// assertions bound to the decompressor
// assumes start_i comes only while idle_o is high
//////////////////////////////////////////////////
`include "snappy_settings.svh"

module decompressor_checker (
	input logic clk,
	input logic rst_n_i,
	input logic start_i,
	input snappy_pkg::comp_len_t compression_length_i,
	input logic wr_ready_i,
	input logic valid_o,
	input logic last_o,
	input snappy_pkg::beat_t data_o,
	input snappy_pkg::byte_mask_t byte_valid_o,
	input logic done_o,
	input logic idle_o,
	input logic scan_pop, // input beat leaves the FIFO
	input snappy_pkg::beat_t in_head
);
	timeunit 1ns;
	timeprecision 100ps;
	import snappy_pkg::*;

	comp_len_t len_q;
	comp_len_t used_q;
	logic [6:0] left_q; // literal bytes still owed
	logic [6:0] left_d;
	logic bad_tag;
	int fails = 0;

	// follow the tags of the beat being popped
	always_comb begin
		left_d = left_q;
		bad_tag = 1'b0;
		for (int i = 0; i < `SNAPPY_BEAT_BYTES; i++) begin
			if (used_q + comp_len_t'(i) < len_q) begin
				if (left_d == '0) begin
					bad_tag = bad_tag || (in_head[i][1:0] != 2'b00);
					left_d = {1'b0, in_head[i][7:2]} + 7'd1;
				end else begin
					left_d = left_d - 7'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			len_q <= '0;
			used_q <= '0;
			left_q <= '0;
		end else if (start_i && idle_o) begin
			len_q <= compression_length_i;
			used_q <= '0;
			left_q <= '0;
		end else if (scan_pop) begin
			used_q <= used_q + comp_len_t'(`SNAPPY_BEAT_BYTES);
			left_q <= left_d;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o && !wr_ready_i |=> valid_o && $stable(data_o)
			&& $stable(byte_valid_o) && $stable(last_o))
	else begin
		$error("output beat changed while wr_ready_i was low");
		fails++;
	end

	// done and idle one cycle after the last beat
	assert property (@(posedge clk) disable iff (!rst_n_i)
		valid_o && wr_ready_i && last_o |=> done_o && idle_o)
	else begin
		$error("done_o or idle_o missing after the last beat");
		fails++;
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		done_o |-> $past(valid_o && wr_ready_i && last_o))
	else begin
		$error("done_o without a last beat transfer");
		fails++;
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		idle_o && !start_i |=> idle_o)
	else begin
		$error("idle_o fell without start_i");
		fails++;
	end

	assert property (@(posedge clk) disable iff (!rst_n_i)
		scan_pop |-> !bad_tag)
	else begin
		$error("tag byte with nonzero low bits on data_i");
		fails++;
	end

endmodule

bind decompressor decompressor_checker checker0 (.*);

//--- tb_decompressor.sv
//////////////////////////////////////////////////
// random literal-only streams sent back to back
// garbage fills each final input beat past the length
//////////////////////////////////////////////////
`include "snappy_settings.svh"

module tb_decompressor;
	timeunit 1ns;
	timeprecision 100ps;
	import snappy_pkg::*;

	localparam int NB = `SNAPPY_BEAT_BYTES;
	localparam int NSTREAMS = 6;

	typedef logic [7:0] byte_q_t [$];

	logic clk = 1'b0;
	logic rst_n_i;
	beat_t data_i;
	logic valid_i;
	logic start_i;
	comp_len_t compression_length_i;
	logic wr_ready_i;
	logic data_fifo_almost_full_o;
	logic done_o;
	logic idle_o;
	logic last_o;
	beat_t data_o;
	byte_mask_t byte_valid_o;
	logic valid_o;

	byte_q_t comp_q [NSTREAMS]; // compressed bytes per stream
	byte_q_t exp_q [NSTREAMS]; // literals not yet seen on the output
	int out_stream = 0;
	int n_beats = 0;
	logic gen_done = 1'b0;
	logic seen_afull = 1'b0;

	decompressor dut0 (.*);

	always #2 clk = ~clk;

	task automatic stop_run(string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_beat(string name, beat_t act, beat_t exp);
		if (act !== exp) begin
			stop_run($sformatf("[FAIL] %0t %s expected %h actual %h",
				$realtime, name, exp, act));
		end
	endtask

	task automatic check_mask(string name, byte_mask_t act, byte_mask_t exp);
		if (act !== exp) begin
			stop_run($sformatf("[FAIL] %0t %s expected %h actual %h",
				$realtime, name, exp, act));
		end
	endtask

	task automatic check_bit(string name, logic act, logic exp);
		if (act !== exp) begin
			stop_run($sformatf("[FAIL] %0t %s expected %b actual %b",
				$realtime, name, exp, act));
		end
	endtask

	// drop the tag bytes, keep the literals in order
	function automatic byte_q_t expected_literals(byte_q_t stream);
		byte_q_t lits;
		int pos;
		int run;
		pos = 0;
		while (pos < stream.size()) begin
			run = int'(stream[pos] >> 2) + 1;
			for (int k = 1; k <= run; k++) begin
				lits.push_back(stream[pos + k]);
			end
			pos += run + 1;
		end
		return lits;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#0.5;
	endtask

	// hold the beat until almost full lets it in
	task automatic send_beat(input beat_t b);
		logic taken;
		data_i = b;
		valid_i = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			taken = !data_fifo_almost_full_o;
			next_cycle();
		end
		valid_i = 1'b0;
	endtask

	initial begin
		int seed;
		int target;
		int tok_len;
		$timeformat(-9, 1, " ns", 10);
		seed = $urandom(20822);
		rst_n_i = 1'b0;
		valid_i = 1'b0;
		start_i = 1'b0;
		data_i = '0;
		compression_length_i = '0;
		wr_ready_i = 1'b0;
		for (int s = 0; s < NSTREAMS; s++) begin
			target = 40 + $urandom_range(260);
			while (comp_q[s].size() < target) begin
				tok_len = 1 + $urandom_range(59);
				comp_q[s].push_back(8'((tok_len - 1) << 2));
				repeat (tok_len) comp_q[s].push_back(8'($urandom));
			end
			if (comp_q[s].size() % NB == 0) begin
				comp_q[s].push_back(8'h00); // one more literal, never a whole beat
				comp_q[s].push_back(8'($urandom));
			end
			exp_q[s] = expected_literals(comp_q[s]);
			n_beats += (comp_q[s].size() + NB - 1) / NB;
		end
		gen_done = 1'b1;
		repeat (3) @(posedge clk);
		#0.5;
		check_bit("valid_o", valid_o, 1'b0);
		check_bit("last_o", last_o, 1'b0);
		check_bit("done_o", done_o, 1'b0);
		check_bit("idle_o", idle_o, 1'b1);
		check_bit("data_fifo_almost_full_o", data_fifo_almost_full_o, 1'b0);
		rst_n_i = 1'b1;
		fork
			begin
				for (int s = 0; s < NSTREAMS; s++) begin
					while (!idle_o) next_cycle();
					start_i = 1'b1;
					compression_length_i = comp_len_t'(comp_q[s].size());
					next_cycle();
					start_i = 1'b0;
				end
			end
			begin
				beat_t beat;
				for (int s = 0; s < NSTREAMS; s++) begin
					for (int b = 0; b < comp_q[s].size(); b += NB) begin
						for (int k = 0; k < NB; k++) begin
							// garbage past the length
							beat[k] = (b + k < comp_q[s].size()) ? comp_q[s][b + k]
								: 8'($urandom);
						end
						send_beat(beat);
						repeat ($urandom_range(2)) next_cycle();
					end
				end
			end
			begin
				repeat (80) next_cycle(); // long stall fills both FIFOs
				while (out_stream < NSTREAMS) begin
					if ($urandom_range(99) < 3) begin
						wr_ready_i = 1'b0;
						repeat (40 + $urandom_range(40)) next_cycle();
					end else begin
						wr_ready_i = ($urandom_range(3) != 0);
						next_cycle();
					end
				end
			end
		join
		next_cycle();
		next_cycle();
		if (!seen_afull) begin
			stop_run("data_fifo_almost_full_o never rose under back-pressure");
		end else if (dut0.checker0.fails != 0) begin
			stop_run("an assertion in the bound checker failed");
		end else begin
			$display("Test passed");
			$finish;
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		beat_t exp_data;
		beat_t act_data;
		byte_mask_t exp_mask;
		int n;
		if (rst_n_i) begin
			if (dut0.checker0.fails != 0) begin
				stop_run("an assertion in the bound checker failed");
			end
			if (data_fifo_almost_full_o) begin
				seen_afull = 1'b1;
			end
			if (valid_o && wr_ready_i && (out_stream >= NSTREAMS)) begin
				stop_run("an output beat came after the last stream had ended");
			end else if (valid_o && wr_ready_i) begin
				n = (exp_q[out_stream].size() < NB) ? exp_q[out_stream].size() : NB;
				exp_data = '0;
				exp_mask = '0;
				act_data = data_o;
				for (int k = 0; k < NB; k++) begin
					if (k < n) begin
						exp_data[k] = exp_q[out_stream].pop_front();
						exp_mask[k] = 1'b1;
					end else begin
						act_data[k] = 8'h00; // not covered by byte_valid
					end
				end
				check_mask("byte_valid_o", byte_valid_o, exp_mask);
				check_beat("data_o", act_data, exp_data);
				check_bit("last_o", last_o, logic'(exp_q[out_stream].size() == 0));
				if (exp_q[out_stream].size() == 0) begin
					out_stream++;
				end
			end
		end
	end

	// limit scales with the number of input beats
	initial begin
		wait (gen_done);
		repeat (40 * n_beats + 2000) @(posedge clk);
		stop_run("timeout, the output stream did not finish in time");
	end

endmodule

//--- sources.f
+incdir+.
snappy_pkg.sv
beat_fifo.sv
token_scanner.sv
literal_packer.sv
output_writer.sv
decompressor.sv
decompressor_checker.sv
tb_decompressor.sv
